// ==== src.f ====
+incdir+tests
common/bchPkg.sv
logic/bitCounter.sv
logic/decodeControl.sv
logic/syndromeUnit.sv
logic/locatorSolver.sv
logic/chienSearch.sv
logic/bchDecoder.sv
tests/bchDecoderTb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --binary --timing --assert -Wno-fatal -j 0
TOP = bchDecoderTb
FILELIST = src.f
OBJDIR = obj_dir
SIM = $(OBJDIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST)) $(wildcard tests/*.svh)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf $(OBJDIR)

// ==== tests/bchModel.svh ====
`ifndef BCH_MODEL_SVH
`define BCH_MODEL_SVH

logic [15:0] lfsrState;

// Fibonacci LFSR with taps 16, 14, 13 and 11, one step per bit taken.
function automatic int randBits(int count);
	int value;
	logic feedback;
	value = 0;
	for (int i = 0; i < count; i++) begin
		feedback = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
		lfsrState = {lfsrState[14:0], feedback};
		value = (value << 1) | int'(feedback);
	end
	return value;
endfunction

// Message on top, remainder of m(x) x^8 divided by g(x) below it.
function automatic logic [CODE_N-1:0] encode(logic [CODE_K-1:0] msg);
	logic [CODE_N-1:0] rem;
	rem = {msg, {(CODE_N - CODE_K){1'b0}}};
	for (int d = CODE_N - 1; d >= CODE_N - CODE_K; d--)
		if (rem[d])
			rem[d -: CODE_N - CODE_K + 1] ^= GEN_POLY;
	return {msg, rem[CODE_N-CODE_K-1:0]};
endfunction

function automatic gfElem alphaPow(int e);
	gfElem value;
	value = gfElem'(1);
	for (int i = 0; i < e % CODE_N; i++)
		value = {value[FIELD_M-2:0], 1'b0} ^ (value[FIELD_M-1] ? PRIM_POLY[FIELD_M-1:0] : '0);
	return value;
endfunction

// Received word evaluated at alpha and alpha^3, packed as {s1, s3}.
function automatic logic [2*FIELD_M-1:0] refSyndromes(logic [CODE_N-1:0] word);
	gfElem s1;
	gfElem s3;
	s1 = '0;
	s3 = '0;
	for (int d = 0; d < CODE_N; d++)
		if (word[d]) begin
			s1 ^= alphaPow(d);
			s3 ^= alphaPow(3 * d);
		end
	return {s1, s3};
endfunction

`endif

// ==== tests/bchDecoderTb.sv ====
module bchDecoderTb import bchPkg::*; ();

	localparam int RESET_CYCLES = 16;
	localparam int WORDS_PER_KIND = 6;
	localparam int NUM_WORDS = 4 * WORDS_PER_KIND;
	localparam int MAX_GAP = 3;
	// Reset, every word with its longest gap, the pipeline drain and some slack.
	localparam int CYCLE_LIMIT = RESET_CYCLES + NUM_WORDS * (CODE_N + MAX_GAP)
		+ DECODE_LATENCY + 40;

	logic clk = 1'b0;
	logic reset;
	logic inValid;
	logic inBit;
	logic outValid;
	logic outBit;
	logic outLast;
	logic [1:0] errCount;
	logic decodeFail;

	// Each entry is {corrected word, error count, fail flag}.
	logic [CODE_N+2:0] expected[$];
	int expStarts[$];
	logic [CODE_N+2:0] head;
	logic headPresent = 1'b0;
	logic outValidSeen = 1'b0;
	int expStart;
	int cycle = 0;
	int outIndex = 0;
	int wordsOut = 0;
	int valueErrors = 0;
	int otherErrors = 0;

	`include "bchModel.svh"

	bchDecoder i_dut (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inBit(inBit),
		.outValid(outValid),
		.outBit(outBit),
		.outLast(outLast),
		.errCount(errCount),
		.decodeFail(decodeFail)
	);

	always #20 clk = ~clk;

	always @(negedge clk)
		outValidSeen <= outValid;

	// Step through the expected word, one output bit per clock.
	always @(posedge clk) begin
		cycle++;
		if (!reset && outValidSeen) begin
			if (outIndex == CODE_N - 1) begin
				void'(expected.pop_front());
				void'(expStarts.pop_front());
				outIndex = 0;
				wordsOut++;
			end else begin
				outIndex++;
			end
		end
		headPresent = expected.size() > 0;
		if (headPresent) begin
			head = expected[0];
			expStart = expStarts[0] + DECODE_LATENCY;
		end
		if (cycle >= CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles, %0d of %0d words came out",
				cycle, wordsOut, NUM_WORDS);
			$display(">>> FAIL");
			$finish;
		end
	end

	validExpected: assert property (@(negedge clk) disable iff (reset) outValid |-> headPresent)
		else begin
			otherErrors++;
			$display("Output bits came out while no word was expected");
		end
	onTime: assert property (@(negedge clk) disable iff (reset)
		outValid && outIndex == 0 |-> cycle == expStart)
		else begin
			otherErrors++;
			$display("Word %0d started at cycle %0d instead of %0d", wordsOut, cycle, expStart);
		end
	noHoles: assert property (@(negedge clk) disable iff (reset) outIndex != 0 |-> outValid)
		else begin
			otherErrors++;
			$display("outValid dropped in the middle of word %0d", wordsOut);
		end
	bitCheck: assert property (@(negedge clk) disable iff (reset)
		outValid |-> outBit == head[CODE_N + 2 - outIndex]) // Word bits sit above count and flag.
		else begin
			valueErrors++;
			$display("FAILED outBit: got %h, expected %h", outBit, head[CODE_N + 2 - outIndex]);
		end
	lastCheck: assert property (@(negedge clk) disable iff (reset)
		outValid |-> outLast == (outIndex == CODE_N - 1))
		else begin
			valueErrors++;
			$display("FAILED outLast: got %h, expected %h", outLast, outIndex == CODE_N - 1);
		end
	countCheck: assert property (@(negedge clk) disable iff (reset) outLast |-> errCount == head[2:1])
		else begin
			valueErrors++;
			$display("FAILED errCount: got %h, expected %h", errCount, head[2:1]);
		end
	failCheck: assert property (@(negedge clk) disable iff (reset) outLast |-> decodeFail == head[0])
		else begin
			valueErrors++;
			$display("FAILED decodeFail: got %h, expected %h", decodeFail, head[0]);
		end

	function automatic int randPosition();
		int pos;
		pos = randBits(4);
		while (pos >= CODE_N)
			pos = randBits(4);
		return pos;
	endfunction

	task automatic sendWord(input logic [CODE_N-1:0] rxWord, input logic [CODE_N-1:0] goodWord,
			input logic [1:0] count, input logic fail, input int gap);
		inValid = 1'b0;
		repeat (gap) @(negedge clk);
		expected.push_back({goodWord, count, fail});
		expStarts.push_back(cycle);
		for (int i = CODE_N - 1; i >= 0; i--) begin
			inValid = 1'b1;
			inBit = rxWord[i]; // Highest degree first.
			@(negedge clk);
		end
	endtask

	initial begin
		logic [CODE_N-1:0] code;
		logic [CODE_N-1:0] flips;
		logic [2*FIELD_M-1:0] syn;
		int first;
		int second;
		logic found;
		reset = 1'b1;
		inValid = 1'b0;
		inBit = 1'b0;
		lfsrState = 16'd45;
		repeat (RESET_CYCLES) @(negedge clk);
		reset = 1'b0;
		for (int w = 0; w < WORDS_PER_KIND; w++) begin
			code = encode(CODE_K'(randBits(CODE_K)));
			sendWord(code, code, 2'd0, 1'b0, 0); // Clean words, back to back.
		end
		for (int w = 0; w < WORDS_PER_KIND; w++) begin
			code = encode(CODE_K'(randBits(CODE_K)));
			first = randPosition();
			sendWord(code ^ (CODE_N'(1) << first), code, 2'd1, 1'b0, randBits(2));
		end
		for (int w = 0; w < WORDS_PER_KIND; w++) begin
			code = encode(CODE_K'(randBits(CODE_K)));
			first = randPosition();
			second = randPosition();
			while (second == first)
				second = randPosition();
			flips = (CODE_N'(1) << first) ^ (CODE_N'(1) << second);
			sendWord(code ^ flips, code, 2'd2, 1'b0, randBits(2));
		end
		// Patterns that look like S1 = 0 and S3 != 0 carry three or more errors.
		for (int w = 0; w < WORDS_PER_KIND; w++) begin
			code = encode(CODE_K'(randBits(CODE_K)));
			found = 1'b0;
			for (int t = 0; t < 1000 && !found; t++) begin
				flips = CODE_N'(randBits(CODE_N));
				syn = refSyndromes(code ^ flips);
				found = syn[2*FIELD_M-1:FIELD_M] == '0 && syn[FIELD_M-1:0] != '0;
			end
			if (!found) begin
				otherErrors++;
				$display("No error pattern with S1 zero and S3 nonzero was found");
			end
			sendWord(code ^ flips, code ^ flips, 2'd0, 1'b1, randBits(2));
		end
		inValid = 1'b0;
		while (wordsOut < NUM_WORDS)
			@(negedge clk);
		@(negedge clk);
		$display("Errors: %0d wrong values, %0d other failures", valueErrors, otherErrors);
		if (valueErrors + otherErrors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

// ==== logic/bchDecoder.sv ====
module bchDecoder import bchPkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic inValid,
	input  logic inBit,
	output logic outValid,
	output logic outBit,
	output logic outLast,
	output logic [1:0] errCount,
	output logic decodeFail
);

	logic [POS_WIDTH-1:0] position;
	logic lastBit;
	logic synClear;
	logic solveStart;
	logic chienLoad;
	gfElem s1;
	gfElem s3;
	gfElem sigma1;
	gfElem sigma2;
	logic [1:0] expectCount;
	logic uncorrectable;

	bitCounter i_bitCounter (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.position(position),
		.lastBit(lastBit)
	);

	decodeControl i_decodeControl (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.position(position),
		.lastBit(lastBit),
		.synClear(synClear),
		.solveStart(solveStart),
		.chienLoad(chienLoad)
	);

	syndromeUnit i_syndromeUnit (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inBit(inBit),
		.synClear(synClear),
		.s1(s1),
		.s3(s3)
	);

	locatorSolver i_locatorSolver (
		.clk(clk),
		.reset(reset),
		.solveStart(solveStart),
		.s1(s1),
		.s3(s3),
		.sigma1(sigma1),
		.sigma2(sigma2),
		.expectCount(expectCount),
		.uncorrectable(uncorrectable)
	);

	chienSearch i_chienSearch (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inBit(inBit),
		.chienLoad(chienLoad),
		.sigma1(sigma1),
		.sigma2(sigma2),
		.expectCount(expectCount),
		.uncorrectable(uncorrectable),
		.outValid(outValid),
		.outBit(outBit),
		.outLast(outLast),
		.errCount(errCount),
		.decodeFail(decodeFail)
	);

endmodule

// ==== logic/chienSearch.sv ====
module chienSearch import bchPkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic inValid,
	input  logic inBit,
	input  logic chienLoad,
	input  gfElem sigma1,
	input  gfElem sigma2,
	input  logic [1:0] expectCount,
	input  logic uncorrectable,
	output logic outValid,
	output logic outBit,
	output logic outLast,
	output logic [1:0] errCount,
	output logic decodeFail
);

	logic [DECODE_LATENCY-1:0] validLine;
	logic [DECODE_LATENCY-1:0] bitLine;
	gfElem term1;
	gfElem term2;
	logic active;
	logic [POS_WIDTH-1:0] runCount;
	logic [1:0] rootCount;
	logic [1:0] expLatched;
	logic uncLatched;
	logic errFlag;

	always_ff @(posedge clk) begin
		if (reset)
			validLine <= '0;
		else
			validLine <= {validLine[DECODE_LATENCY-2:0], inValid};
	end

	always_ff @(posedge clk) begin
		bitLine <= {bitLine[DECODE_LATENCY-2:0], inBit};
	end

	// First bit out has degree 14, so start at alpha^-14 and alpha^-28.
	always_ff @(posedge clk) begin
		if (chienLoad) begin
			term1 <= gfMul(sigma1, ALPHA);
			term2 <= gfMul(sigma2, gfMul(ALPHA, ALPHA));
		end else if (active) begin
			term1 <= gfMul(term1, ALPHA);
			term2 <= gfMul(term2, gfMul(ALPHA, ALPHA));
		end
	end

	assign errFlag = active && !uncLatched && ((term1 ^ term2) == 4'b0001);

	always_ff @(posedge clk) begin
		if (reset) begin
			active <= 1'b0;
			runCount <= '0;
			rootCount <= 2'd0;
			expLatched <= 2'd0;
			uncLatched <= 1'b0;
		end else if (chienLoad) begin
			// Solver outputs move on with the next word, keep this word's verdict.
			active <= 1'b1;
			runCount <= '0;
			rootCount <= 2'd0;
			expLatched <= expectCount;
			uncLatched <= uncorrectable;
		end else if (active) begin
			rootCount <= rootCount + 2'(errFlag);
			if (runCount == POS_WIDTH'(CODE_N - 1)) begin
				active <= 1'b0;
				runCount <= '0;
			end else begin
				runCount <= runCount + 1'b1;
			end
		end
	end

	assign outValid = validLine[DECODE_LATENCY-1];
	assign outBit = bitLine[DECODE_LATENCY-1] ^ errFlag; // Correct the bit.
	assign outLast = active && (runCount == POS_WIDTH'(CODE_N - 1));
	assign errCount = rootCount + 2'(errFlag);
	assign decodeFail = outLast && (uncLatched || errCount != expLatched);

	// The run counter and the delay line must stay aligned.
	lastWithValid: assert property (@(posedge clk) disable iff (reset)
		outLast |-> outValid);

endmodule

// ==== logic/locatorSolver.sv ====
module locatorSolver import bchPkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic solveStart,
	input  gfElem s1,
	input  gfElem s3,
	output gfElem sigma1,
	output gfElem sigma2,
	output logic [1:0] expectCount,
	output logic uncorrectable
);

	gfElem capS1;
	gfElem capS3;
	gfElem capS1Cube;
	logic stageValid;
	gfElem sigma2Next;
	logic [1:0] countNext;
	logic uncNext;

	always_ff @(posedge clk) begin
		if (solveStart) begin
			capS1 <= s1;
			capS3 <= s3;
			capS1Cube <= gfMul(gfMul(s1, s1), s1);
		end
	end

	// Closed form of the t=2 locator.
	always_comb begin
		sigma2Next = '0;
		countNext = 2'd0;
		uncNext = 1'b0;
		if (capS1 == '0) begin
			uncNext = (capS3 != '0);
		end else if (capS3 == capS1Cube) begin
			countNext = 2'd1;
		end else begin
			sigma2Next = gfMul(capS3 ^ capS1Cube, gfInv(capS1));
			countNext = 2'd2;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			stageValid <= 1'b0;
			sigma1 <= '0;
			sigma2 <= '0;
			expectCount <= 2'd0;
			uncorrectable <= 1'b0;
		end else begin
			stageValid <= solveStart;
			if (stageValid) begin
				sigma1 <= capS1;
				sigma2 <= sigma2Next;
				expectCount <= countNext;
				uncorrectable <= uncNext;
			end
		end
	end

	// Multiplying sigma2 back by S1 must give S3 plus S1 cubed.
	sigma2MatchesSyndromes: assert property (@(posedge clk) disable iff (reset)
		stageValid && countNext == 2'd2 |-> gfMul(sigma2Next, capS1) == (capS3 ^ capS1Cube));

endmodule

// ==== logic/syndromeUnit.sv ====
module syndromeUnit import bchPkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic inValid,
	input  logic inBit,
	input  logic synClear,
	output gfElem s1,
	output gfElem s3
);

	gfElem bitElem;
	gfElem s1Next;
	gfElem s3Next;

	assign bitElem = {{(FIELD_M - 1){1'b0}}, inBit};

	// Horner step, r(x) evaluated at alpha and alpha^3.
	always_comb begin
		if (synClear) begin
			s1Next = bitElem;
			s3Next = bitElem;
		end else begin
			s1Next = gfMul(s1, ALPHA) ^ bitElem;
			s3Next = gfMul(s3, gfPow(ALPHA, POS_WIDTH'(3))) ^ bitElem;
		end
	end

	// Values hold between words so the solver can sample them.
	always_ff @(posedge clk) begin
		if (reset) begin
			s1 <= '0;
			s3 <= '0;
		end else if (inValid) begin
			s1 <= s1Next;
			s3 <= s3Next;
		end
	end

endmodule

// ==== logic/decodeControl.sv ====
module decodeControl import bchPkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic inValid,
	input  logic [POS_WIDTH-1:0] position,
	input  logic lastBit,
	output logic synClear,
	output logic solveStart,
	output logic chienLoad
);

	typedef enum logic {
		Idle,
		Collect
	} stateType;

	stateType state;
	logic [SOLVE_LATENCY-1:0] strobes;

	// A word always starts from Idle, also when words run back to back.
	assign synClear = (state == Idle) && inValid;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= Idle;
		end else begin
			case (state)
				Idle:
					if (inValid && position == '0)
						state <= Collect;
				Collect:
					if (lastBit)
						state <= Idle;
				default:
					state <= Idle;
			endcase
		end
	end

	// Strobes of two words may be in flight here at once.
	always_ff @(posedge clk) begin
		if (reset)
			strobes <= '0;
		else
			strobes <= {strobes[SOLVE_LATENCY-2:0], lastBit};
	end

	assign solveStart = strobes[0]; // Syndromes are final this cycle.
	assign chienLoad = strobes[SOLVE_LATENCY-1];

	// A word must arrive as one unbroken run of CODE_N bits.
	collectNoGap: assert property (@(posedge clk) disable iff (reset)
		state == Collect |-> inValid);

endmodule

// ==== logic/bitCounter.sv ====
module bitCounter import bchPkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic inValid,
	output logic [POS_WIDTH-1:0] position,
	output logic lastBit
);

	assign lastBit = inValid && (position == POS_WIDTH'(CODE_N - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			position <= '0;
		end else if (inValid) begin
			if (lastBit)
				position <= '0; // Wrap for the next word.
			else
				position <= position + 1'b1;
		end
	end

endmodule

// ==== common/bchPkg.sv ====
package bchPkg;

	// Code and field for the binary (15,7) BCH code, t = 2.
	localparam int CODE_N = 15;
	localparam int CODE_K = 7;
	localparam int FIELD_M = 4;
	localparam logic [FIELD_M:0] PRIM_POLY = 5'b10011; // x^4 + x + 1.
	localparam logic [CODE_N-CODE_K:0] GEN_POLY = 9'b111010001; // x^8+x^7+x^6+x^4+1.

	localparam int POS_WIDTH = 4;
	localparam int SOLVE_LATENCY = 3; // Last input bit to first output bit.
	localparam int DECODE_LATENCY = CODE_N + SOLVE_LATENCY;

	typedef logic [FIELD_M-1:0] gfElem;

	localparam gfElem ALPHA = 4'b0010;

	// Shift-and-add multiply, reducing by the primitive polynomial each step.
	function automatic gfElem gfMul(gfElem a, gfElem b);
		gfElem acc;
		gfElem shifted;
		acc = '0;
		shifted = a;
		for (int i = 0; i < FIELD_M; i++) begin
			if (b[i])
				acc ^= shifted;
			shifted = {shifted[FIELD_M-2:0], 1'b0} ^
				(shifted[FIELD_M-1] ? PRIM_POLY[FIELD_M-1:0] : '0);
		end
		return acc;
	endfunction

	function automatic gfElem gfPow(gfElem a, logic [POS_WIDTH-1:0] e);
		gfElem result;
		gfElem base;
		result = 4'b0001;
		base = a;
		for (int i = 0; i < POS_WIDTH; i++) begin
			if (e[i])
				result = gfMul(result, base);
			base = gfMul(base, base);
		end
		return result;
	endfunction

	// a^14 = a^-1 for any nonzero a.
	function automatic gfElem gfInv(gfElem a);
		return gfPow(a, POS_WIDTH'(CODE_N - 1));
	endfunction

endpackage
